//--- rtl/serdes_pkg.sv
/*
 * Stream serializer subsystem package
 * Width constants, the stream beat, the serializer control word,
 * the APB request and response structs and the register map
 */
package serdes_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int unsigned DATA_WIDTH      = 32;             // Payload bits per beat
  localparam int unsigned STRB_WIDTH      = DATA_WIDTH / 8; // One strobe per byte
  localparam int unsigned STREAM_ID_WIDTH = 10;             // Stream index field
  localparam int unsigned APB_ADDR_WIDTH  = 8;              // Byte address of a register
  localparam int unsigned APB_DATA_WIDTH  = 32;             // Register word

  // Bit positions inside the registers
  localparam int unsigned CTRL_ENABLE_BIT = 0;              // REG_CTRL, counter runs when set
  localparam int unsigned CMD_RESTART_BIT = 0;              // REG_CMD, jump to first stream
  localparam int unsigned CMD_FLUSH_BIT   = 1;              // REG_CMD, empty all buffers

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Structs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;                            // Payload
    logic [STRB_WIDTH-1:0] strb;                            // Byte enables
  } stream_beat_t;

  typedef struct packed {
    logic                       restart;                    // Load first_stream into the counter
    logic [STREAM_ID_WIDTH-1:0] first_stream;               // Stream picked on restart
  } ctrl_serdes_t;

  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;                      // Tied high, no wait states
    logic                      pslverr;                     // Tied low, no errors
  } apb_rsp_t;

  // Register word addresses
  typedef enum logic [APB_ADDR_WIDTH-1:0] {
    REG_CTRL  = 8'h00,                                      // Bit 0 enable
    REG_FIRST = 8'h04,                                      // First stream after restart
    REG_CMD   = 8'h08,                                      // Self-clearing commands
    REG_BEATS = 8'h0C                                       // Output beat count, read-only
  } serdes_reg_e;

endpackage

//--- rtl/stream_fifo.sv
/*
 * Per-stream input buffer
 * Circular buffer with valid/ready on both sides and a one-cycle flush
 */
module stream_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     push_valid_i,
  input  serdes_pkg::stream_beat_t push_beat_i,
  output logic                     push_ready_o,
  output logic                     pop_valid_o,
  output serdes_pkg::stream_beat_t pop_beat_o,
  input  logic                     pop_ready_i
);

  localparam int unsigned PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  serdes_pkg::stream_beat_t mem_q [FIFO_DEPTH];             // Beat storage
  logic [PTR_WIDTH-1:0]     wr_ptr_q;                       // Next slot to fill
  logic [PTR_WIDTH-1:0]     rd_ptr_q;                       // Oldest beat
  logic [CNT_WIDTH-1:0]     count_q;                        // Occupancy
  logic                     push;
  logic                     pop;

  // Advance a pointer, wrapping at the last slot
  function automatic logic [PTR_WIDTH-1:0] ptr_next(input logic [PTR_WIDTH-1:0] ptr);
    if (ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_WIDTH'(1);
  endfunction

  assign push_ready_o = (count_q != CNT_WIDTH'(FIFO_DEPTH)); // Low only when full
  assign pop_valid_o  = (count_q != '0);
  assign pop_beat_o   = mem_q[rd_ptr_q];                     // Head of the queue
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_beat_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin                             // Drops whatever is stored
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_next(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + CNT_WIDTH'(1);
        2'b01:   count_q <= count_q - CNT_WIDTH'(1);
        default: count_q <= count_q;                        // Both or neither
      endcase
    end
  end

  // Occupancy stays within the buffer over any push/pop sequence
  a_count_bound : assert property (
    @(posedge clk_i) disable iff (!rst_ni) count_q <= CNT_WIDTH'(FIFO_DEPTH)
  );

endmodule

//--- rtl/stream_serialize.sv
/*
 * Round-robin stream serializer
 * Takes one beat from each buffered stream in turn and merges them onto
 * one output stream, with restart, clear and an enable that freezes the
 * stream counter
 */
module stream_serialize #(
  parameter int unsigned NB_STREAMS = 4
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      clear_i,
  input  logic                                      enable_i,
  input  serdes_pkg::ctrl_serdes_t                  ctrl_i,
  input  logic                     [NB_STREAMS-1:0] in_valid_i,
  input  serdes_pkg::stream_beat_t [NB_STREAMS-1:0] in_beat_i,
  output logic                     [NB_STREAMS-1:0] in_ready_o,
  output logic                                      pop_valid_o,
  output serdes_pkg::stream_beat_t                  pop_beat_o,
  input  logic                                      pop_ready_i
);

  localparam int unsigned CNT_WIDTH = (NB_STREAMS > 1) ? $clog2(NB_STREAMS) : 1;

  logic [CNT_WIDTH-1:0] stream_cnt_d;
  logic [CNT_WIDTH-1:0] stream_cnt_q;                       // Selected stream
  logic                 transfer;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Datapath, purely combinational
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign pop_valid_o = in_valid_i[stream_cnt_q];
  assign pop_beat_o  = in_beat_i[stream_cnt_q];
  assign transfer    = pop_valid_o & pop_ready_i;

  always_comb begin
    in_ready_o               = '0;                          // Other streams wait their turn
    in_ready_o[stream_cnt_q] = pop_ready_i;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stream counter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    stream_cnt_d = stream_cnt_q;
    if (clear_i) begin
      stream_cnt_d = '0;                                    // Flush goes back to stream 0
    end else if (ctrl_i.restart) begin
      stream_cnt_d = ctrl_i.first_stream[CNT_WIDTH-1:0];
    end else if (transfer) begin
      if (stream_cnt_q == CNT_WIDTH'(NB_STREAMS - 1)) begin
        stream_cnt_d = '0;                                  // Wrap after the last stream
      end else begin
        stream_cnt_d = stream_cnt_q + CNT_WIDTH'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stream_cnt_q <= '0;
    end else if (enable_i) begin                            // Frozen while disabled
      stream_cnt_q <= stream_cnt_d;
    end
  end

  // A restart must name a stream that exists, the counter only holds its low bits
  a_first_in_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ctrl_i.restart |-> (ctrl_i.first_stream < NB_STREAMS)
  );

endmodule

//--- rtl/serdes_apb_regs.sv
/*
 * Serializer configuration registers
 * APB slave with enable, first stream and command registers, turning
 * command writes into one-cycle restart and flush pulses, and counting
 * output beats
 */
module serdes_apb_regs #(
  parameter int unsigned NB_STREAMS = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  serdes_pkg::apb_req_t     apb_req_i,
  output serdes_pkg::apb_rsp_t     apb_rsp_o,
  input  logic                     pop_valid_i,
  input  logic                     pop_ready_i,
  output logic                     enable_o,
  output serdes_pkg::ctrl_serdes_t ctrl_o,
  output logic                     flush_o
);

  serdes_pkg::serdes_reg_e                reg_addr;
  logic                                   wr_en;             // Access phase of a write
  logic                                   enable_q;
  logic [serdes_pkg::STREAM_ID_WIDTH-1:0] first_q;
  logic                                   restart_q;         // One-cycle pulse
  logic                                   flush_q;           // One-cycle pulse
  logic [serdes_pkg::APB_DATA_WIDTH-1:0]  beats_q;
  logic [serdes_pkg::APB_DATA_WIDTH-1:0]  rdata;

  // The stream count has to fit the index field of the control word
  if (NB_STREAMS > (1 << serdes_pkg::STREAM_ID_WIDTH)) begin : gen_nb_streams_check
    $error("NB_STREAMS exceeds the stream index field");
  end

  assign reg_addr = serdes_pkg::serdes_reg_e'(apb_req_i.paddr);
  assign wr_en    = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q  <= 1'b1;                                    // Running out of reset
      first_q   <= '0;
      restart_q <= 1'b0;
      flush_q   <= 1'b0;
    end else begin
      restart_q <= 1'b0;                                    // Commands clear themselves
      flush_q   <= 1'b0;
      if (wr_en) begin
        case (reg_addr)
          serdes_pkg::REG_CTRL:  enable_q <= apb_req_i.pwdata[serdes_pkg::CTRL_ENABLE_BIT];
          serdes_pkg::REG_FIRST: first_q  <= apb_req_i.pwdata[serdes_pkg::STREAM_ID_WIDTH-1:0];
          serdes_pkg::REG_CMD: begin
            restart_q <= apb_req_i.pwdata[serdes_pkg::CMD_RESTART_BIT];
            flush_q   <= apb_req_i.pwdata[serdes_pkg::CMD_FLUSH_BIT];
          end
          default: ;                                        // REG_BEATS is read-only
        endcase
      end
    end
  end

  // Output beat counter, cleared together with the buffers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beats_q <= '0;
    end else if (flush_q) begin
      beats_q <= '0;
    end else if (pop_valid_i && pop_ready_i) begin
      beats_q <= beats_q + 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    rdata = '0;                                             // Unmapped and REG_CMD read 0
    case (reg_addr)
      serdes_pkg::REG_CTRL:  rdata[serdes_pkg::CTRL_ENABLE_BIT] = enable_q;
      serdes_pkg::REG_FIRST: rdata[serdes_pkg::STREAM_ID_WIDTH-1:0] = first_q;
      serdes_pkg::REG_BEATS: rdata = beats_q;
      default: ;
    endcase
  end

  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = 1'b0;

  assign enable_o            = enable_q;
  assign ctrl_o.restart      = restart_q;
  assign ctrl_o.first_stream = first_q;
  assign flush_o             = flush_q;

  // A setup phase is always followed by its access phase
  a_apb_setup_access : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (apb_req_i.psel && !apb_req_i.penable) |=> (apb_req_i.psel && apb_req_i.penable)
  );

endmodule

//--- rtl/stream_serdes_top.sv
/*
 * Streaming serializer subsystem
 * One input buffer per stream feeding a round-robin serializer,
 * configured through an APB register block
 */
module stream_serdes_top #(
  parameter int unsigned NB_STREAMS = 4,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                     [NB_STREAMS-1:0] push_valid_i,
  input  serdes_pkg::stream_beat_t [NB_STREAMS-1:0] push_beat_i,
  output logic                     [NB_STREAMS-1:0] push_ready_o,
  output logic                                      pop_valid_o,
  output serdes_pkg::stream_beat_t                  pop_beat_o,
  input  logic                                      pop_ready_i,
  input  serdes_pkg::apb_req_t                      apb_req_i,
  output serdes_pkg::apb_rsp_t                      apb_rsp_o
);

  logic                     [NB_STREAMS-1:0] fifo_valid;    // Buffer to serializer
  serdes_pkg::stream_beat_t [NB_STREAMS-1:0] fifo_beat;
  logic                     [NB_STREAMS-1:0] fifo_ready;
  logic                                      enable;
  serdes_pkg::ctrl_serdes_t                  ctrl;
  logic                                      flush;          // Empties buffers, clears counter

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage 1, input buffers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < NB_STREAMS; i++) begin : gen_fifo
    stream_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .flush_i      (flush),
      .push_valid_i (push_valid_i[i]),
      .push_beat_i  (push_beat_i[i]),
      .push_ready_o (push_ready_o[i]),
      .pop_valid_o  (fifo_valid[i]),
      .pop_beat_o   (fifo_beat[i]),
      .pop_ready_i  (fifo_ready[i])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage 2, serializer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  stream_serialize #(
    .NB_STREAMS (NB_STREAMS)
  ) i_serialize (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (flush),
    .enable_i    (enable),
    .ctrl_i      (ctrl),
    .in_valid_i  (fifo_valid),
    .in_beat_i   (fifo_beat),
    .in_ready_o  (fifo_ready),
    .pop_valid_o (pop_valid_o),
    .pop_beat_o  (pop_beat_o),
    .pop_ready_i (pop_ready_i)
  );

  // Configuration, watching the output handshake for the beat count
  serdes_apb_regs #(
    .NB_STREAMS (NB_STREAMS)
  ) i_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .apb_req_i   (apb_req_i),
    .apb_rsp_o   (apb_rsp_o),
    .pop_valid_i (pop_valid_o),
    .pop_ready_i (pop_ready_i),
    .enable_o    (enable),
    .ctrl_o      (ctrl),
    .flush_o     (flush)
  );

endmodule

//--- verification/tb_clk_gen.sv
/*
 * Testbench clock and reset
 * Free-running 10 ns clock and an active-low reset held for a number of cycles
 */
module tb_clk_gen #(
  parameter int unsigned HALF_PERIOD  = 5,
  parameter int unsigned RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;                  // 10 ns period with the default
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_no = 1'b1;                                       // Released off the edge
  end

endmodule

//--- verification/tb_serdes.sv
/*
 * Testbench for the streaming serializer subsystem
 * Runs the operations of the tests file against the DUT, models the
 * round-robin order, the enable freeze, restart and flush on the pushed
 * beats, and checks every output beat, handshake and register read
 */
module tb_serdes;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NB_STREAMS = 4;
  localparam int unsigned FIFO_DEPTH = 4;
  localparam logic [31:0] LFSR_SEED  = 32'h377a_1039;
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;       // Maximal length, Galois form

  typedef struct packed {
    logic [7:0]  kind;                                      // Operation letter
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] n;                                         // Repeat count of a push
  } test_op_t;

  logic                                      clk;
  logic                                      rst_n;
  logic                     [NB_STREAMS-1:0] push_valid = '0;
  serdes_pkg::stream_beat_t [NB_STREAMS-1:0] push_beat  = '0;
  logic                     [NB_STREAMS-1:0] push_ready;
  logic                                      pop_valid;
  serdes_pkg::stream_beat_t                  pop_beat;
  logic                                      pop_ready  = 1'b0;
  serdes_pkg::apb_req_t                      apb_req    = '0;
  serdes_pkg::apb_rsp_t                      apb_rsp;

  test_op_t                 ops [$];
  serdes_pkg::stream_beat_t push_q [NB_STREAMS][$];         // Beats still to be offered
  serdes_pkg::stream_beat_t exp_q  [NB_STREAMS][$];         // Model of each buffer
  logic [NB_STREAMS-1:0]    push_taken   = '0;
  int unsigned              mode         = 0;               // 0 ready, 1 random, 2 stalled
  logic [31:0]              lfsr_state   = LFSR_SEED;
  int unsigned              exp_cnt      = 0;               // Model of the stream counter
  logic                     model_en     = 1'b1;
  int unsigned              model_first  = 0;
  logic                     restart_pend = 1'b0;
  logic                     flush_pend   = 1'b0;
  int unsigned              beat_count   = 0;               // Model of REG_BEATS
  int unsigned              seen_beats   = 0;
  int unsigned              waited       = 0;
  int unsigned              checks       = 0;
  int unsigned              value_errors = 0;
  int unsigned              other_errors = 0;
  int unsigned              cycle_count  = 0;
  int unsigned              cycle_limit  = 0;

  tb_clk_gen #(
    .HALF_PERIOD  (5),
    .RESET_CYCLES (5)
  ) i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  stream_serdes_top #(
    .NB_STREAMS (NB_STREAMS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut0 (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .push_valid_i (push_valid),
    .push_beat_i  (push_beat),
    .push_ready_o (push_ready),
    .pop_valid_o  (pop_valid),
    .pop_beat_o   (pop_beat),
    .pop_ready_i  (pop_ready),
    .apb_req_i    (apb_req),
    .apb_rsp_o    (apb_rsp)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ LFSR_TAPS;
    end
    return state >> 1;
  endfunction

  task automatic check_beat(input serdes_pkg::stream_beat_t got,
                            input serdes_pkg::stream_beat_t exp, input int unsigned stream);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("Fail at %0t: beat of stream %0d is %h/%h, expected %h/%h", $time, stream,
               got.data, got.strb, exp.data, exp.strb);
    end
  endtask

  task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp,
                             input logic [7:0] addr);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("Fail at %0t: register %h read %h, expected %h", $time, addr, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_counts();
    $display("Checks: %0d, wrong values: %0d, other errors: %0d",
             checks, value_errors, other_errors);
  endtask

  // Lines starting with # are comments, fields are hex
  task automatic load_tests();
    int          fd;
    string       line;
    string       tok;
    test_op_t    op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] n;
    fd = $fopen("verification/serdes_tests.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open the tests file verification/serdes_tests.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if ($sscanf(line, "%s", tok) < 1) continue;            // Blank line
      if (tok.getc(0) == "#") continue;
      a = '0;
      b = '0;
      c = '0;
      n = 1;                                                 // One beat unless a count is given
      void'($sscanf(line, "%s %h %h %h %h", tok, a, b, c, n));
      op.kind = tok.getc(0);
      op.a    = a;
      op.b    = b;
      op.c    = c;
      op.n    = n;
      ops.push_back(op);
    end
    $fclose(fd);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // APB master, two cycles per transfer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    apb_req.psel    = 1'b1;                                  // Setup phase
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;                                  // Access phase
    #1;
    check_flag(apb_rsp.pready, 1'b1, "pready");              // No wait states
    check_flag(apb_rsp.pslverr, 1'b0, "pslverr");
    @(posedge clk);
    #1;
    apb_req = '0;
    // The DUT registers took the write at the last edge
    case (addr)
      serdes_pkg::REG_CTRL:  model_en = data[serdes_pkg::CTRL_ENABLE_BIT];
      serdes_pkg::REG_FIRST: model_first = data[serdes_pkg::STREAM_ID_WIDTH-1:0];
      serdes_pkg::REG_CMD: begin
        restart_pend = data[serdes_pkg::CMD_RESTART_BIT];
        flush_pend   = data[serdes_pkg::CMD_FLUSH_BIT];
      end
      default: ;
    endcase
  endtask

  task automatic apb_read_check(input logic [7:0] addr, input logic [31:0] exp_data,
                                input bit exp_is_count);
    logic [31:0] exp;
    @(posedge clk);
    #1;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    apb_req.pwdata  = '0;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    #1;                                                      // Read data settled in the access phase
    exp = exp_is_count ? 32'(beat_count) : exp_data;
    check_rdata(apb_rsp.prdata, exp, addr);
    check_flag(apb_rsp.pready, 1'b1, "pready");
    check_flag(apb_rsp.pslverr, 1'b0, "pslverr");
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic wait_output(input int unsigned count);
    int unsigned target;
    target = waited + count;
    while (seen_beats < target) @(posedge clk);
    waited = target;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stream drivers, each stream offers its own queue
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : drive
    forever begin
      @(posedge clk);
      #1;
      for (int s = 0; s < NB_STREAMS; s++) begin
        if (push_taken[s]) begin
          push_q[s].delete(0);                               // Accepted at the last edge
          push_taken[s] = 1'b0;
        end
        if (push_q[s].size() != 0) begin
          push_valid[s] = 1'b1;
          push_beat[s]  = push_q[s][0];
        end else begin
          push_valid[s] = 1'b0;
          push_beat[s]  = '0;
        end
      end
      case (mode)
        0: pop_ready = 1'b1;
        1: begin
          lfsr_state = lfsr_next(lfsr_state);
          pop_ready  = lfsr_state[0];
        end
        default: pop_ready = 1'b0;
      endcase
    end
  end

  // Sampled mid-cycle, the values describe the handshakes of the next edge
  initial begin : monitor
    int unsigned              sel;
    logic                     exp_valid;
    logic                     fired;
    logic                     flush_now;
    serdes_pkg::stream_beat_t exp_beat;
    forever begin
      @(negedge clk);
      if (rst_n) begin
        for (int s = 0; s < NB_STREAMS; s++) begin
          check_flag(push_ready[s], exp_q[s].size() < FIFO_DEPTH,
                     $sformatf("push_ready of stream %0d", s));
        end
        sel       = exp_cnt;
        exp_valid = (exp_q[sel].size() != 0);
        check_flag(pop_valid, exp_valid, "pop_valid");
        fired     = exp_valid && pop_ready;
        if (pop_valid && pop_ready) begin
          seen_beats++;
        end
        if (fired) begin
          exp_beat = exp_q[sel].pop_front();
          check_beat(pop_beat, exp_beat, sel);
          beat_count++;
        end
        flush_now = flush_pend;
        if (model_en) begin                                  // Counter frozen otherwise
          if (flush_pend) exp_cnt = 0;
          else if (restart_pend) exp_cnt = model_first;
          else if (fired) exp_cnt = (exp_cnt + 1) % NB_STREAMS;
        end
        restart_pend = 1'b0;
        flush_pend   = 1'b0;
        for (int s = 0; s < NB_STREAMS; s++) begin
          if (push_valid[s] && push_ready[s]) begin
            push_taken[s] = 1'b1;
            if (!flush_now) exp_q[s].push_back(push_beat[s]); // Flush drops a beat in flight
          end
        end
        if (flush_now) begin
          for (int s = 0; s < NB_STREAMS; s++) exp_q[s].delete();
          beat_count = 0;
        end
      end
    end
  end

  initial begin : watchdog
    while (cycle_limit == 0 || cycle_count <= cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    other_errors++;
    $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
    report_counts();
    $display("Finished with errors");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : run
    serdes_pkg::stream_beat_t beat;
    load_tests();
    cycle_limit = 200 * ops.size() + 100;
    wait (rst_n === 1'b1);
    @(posedge clk);
    foreach (ops[i]) begin
      case (ops[i].kind)
        "W": apb_write(ops[i].a[7:0], ops[i].b);
        "R": apb_read_check(ops[i].a[7:0], ops[i].b, 1'b0);
        "B": apb_read_check(serdes_pkg::REG_BEATS, '0, 1'b1);
        "O": wait_output(ops[i].a);
        "M": mode = ops[i].a;
        "P": begin
          if (ops[i].a >= NB_STREAMS) begin
            other_errors++;
            $display("Test line %0d pushes to stream %0d, which does not exist", i, ops[i].a);
          end else begin
            for (int k = 0; k < ops[i].n; k++) begin
              beat.data = ops[i].b + k;                      // Successive payloads
              beat.strb = ops[i].c[serdes_pkg::STRB_WIDTH-1:0];
              push_q[ops[i].a].push_back(beat);
            end
          end
        end
        default: begin
          other_errors++;
          $display("Test line %0d has an unknown operation", i);
        end
      endcase
    end
    repeat (2) @(posedge clk);
    for (int s = 0; s < NB_STREAMS; s++) begin
      if (exp_q[s].size() != 0 || push_q[s].size() != 0) begin
        other_errors++;
        $display("Stream %0d still holds beats at the end of the run", s);
      end
    end
    report_counts();
    if (value_errors == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- verification/serdes_tests.txt
# Serializer tests, one operation per line, fields in hex
# W addr data | R addr expected | P stream data strb [count] | O beats | M mode | B
# Mode 0 holds pop_ready high, 1 takes it from the LFSR, 2 holds it low
# B reads REG_BEATS and compares with the transfers seen so far
R 00 00000001
R 04 00000000
R 08 00000000
R 10 00000000
B
# Round-robin order over all four streams
P 0 a0000001 f 2
P 1 a1000001 3 2
P 2 a2000001 c 2
P 3 a3000001 1 2
O 8
B
# Restart at stream 2
W 04 00000002
W 08 00000001
R 04 00000002
P 0 b0000001 f
P 1 b1000001 e
P 2 b2000001 d
P 3 b3000001 b
O 4
# Enable cleared, the counter stays on stream 2
W 00 00000000
R 00 00000000
P 2 c2000001 5 4
O 4
W 00 00000001
# Random back-pressure with bursts longer than a buffer
M 1
P 0 d0000001 f 6
P 1 d1000001 7 6
P 2 d2000001 e 6
P 3 d3000001 5 6
O 18
B
# Flush with beats held in the buffers
M 2
P 0 e0000001 f
P 1 e1000001 f 2
W 08 00000002
B
R 0c 00000000
M 0
P 1 f1000001 2
P 0 f0000001 4
P 3 f3000001 8
P 2 f2000001 1
O 4
B

//--- list.f
rtl/serdes_pkg.sv
rtl/stream_fifo.sv
rtl/stream_serialize.sv
rtl/serdes_apb_regs.sv
rtl/stream_serdes_top.sv
verification/tb_clk_gen.sv
verification/tb_serdes.sv

//--- Bender.yml
package:
  name: stream_serdes

sources:
  - rtl/serdes_pkg.sv
  - rtl/stream_fifo.sv
  - rtl/stream_serialize.sv
  - rtl/serdes_apb_regs.sv
  - rtl/stream_serdes_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_serdes.sv
